//--- rv_mem_stage.f
rtl/rv_isa_pkg.sv
rtl/mem_map_pkg.sv
rtl/mem_ctrl_if.sv
rtl/mem_control.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/rv_mem_stage.sv
dv/tb_clock_gen.sv
dv/rv_mem_stage_properties.sv
dv/rv_mem_stage_tb.sv

//--- Makefile
TOP := rv_mem_stage_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f rv_mem_stage.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- dv/rv_mem_stage_tb.sv
`timescale 1ns/1ns

module rv_mem_stage_tb import rv_isa_pkg::*, mem_map_pkg::*; ();

    localparam logic [3:0]  IO_REGION = 4'hA;
    localparam logic [31:0] NOP       = 32'h00000013;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] wb_inst;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] rs2_data;
        logic [31:0] wb_data;
        logic [31:0] rd_data;
    } entry_t;

    typedef struct {
        logic [3:0]  mask;
        logic [31:0] waddr;
        logic [31:0] wdata;
        mem_target_t tgt;
        logic        ld_v;
        logic [31:0] ld_d;
        logic        br;
        logic [31:0] raddr;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] inst;
    logic [31:0] wb_inst;
    logic [31:0] rs2_data;
    logic [31:0] wb_data;
    logic [31:0] rd_data;
    logic        br_inst;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_mask;
    logic        dmem_en;
    logic        imem_en;
    logic        io_en;
    logic [31:0] ld_data;
    logic        ld_valid;

    entry_t table_q[$];
    logic   table_ready = 1'b0;

    tb_clock_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (16)
    ) u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_mem_stage #(
        .IO_REGION (IO_REGION)
    ) DUT (.*);

    function automatic logic [31:0] encode(opcode_t opc, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs2);
        return {7'h00, rs2, 5'd1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] data_addr(logic [1:0] off);
        return {4'h1, 26'($urandom), off};
    endfunction

    function automatic logic [31:0] pc_value(logic pc30);
        return {1'b0, pc30, 28'($urandom), 2'b00};
    endfunction

    task automatic add_entry(input logic [31:0] i_word, input logic [31:0] wb_word,
                             input logic [31:0] pc_v, input logic [31:0] addr_v,
                             input logic [31:0] rd_v);
        entry_t e;
        e.inst     = i_word;
        e.wb_inst  = wb_word;
        e.pc       = pc_v;
        e.addr     = addr_v;
        e.rs2_data = $urandom;
        e.wb_data  = $urandom;
        e.rd_data  = rd_v;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] wb_nop;
        logic [31:0] wb_rd9;
        logic [31:0] sw_rs9;
        logic [31:0] rdv;
        logic [2:0]  kinds [5];
        opcode_t     others [6];
        kinds  = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
        others = '{OPC_ARI_RTYPE, OPC_ARI_ITYPE, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};
        wb_nop = encode(OPC_ARI_ITYPE, 3'd0, 5'd0, 5'd0);
        wb_rd9 = encode(OPC_ARI_RTYPE, 3'd0, 5'd9, 5'd3);
        sw_rs9 = encode(OPC_STORE, F3_SW, 5'd0, 5'd9);
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 4; off++) begin
                add_entry(encode(OPC_STORE, 3'(sz), 5'(off), 5'd7), wb_nop, pc_value(1'b0),
                          data_addr(2'(off)), $urandom);
            end
        end
        // I/O wins over pc[30]
        add_entry(sw_rs9, wb_nop, pc_value(1'b0), {IO_REGION, 26'($urandom), 2'b00}, $urandom);
        add_entry(sw_rs9, wb_nop, pc_value(1'b1), data_addr(2'd0), $urandom);
        add_entry(sw_rs9, wb_nop, pc_value(1'b1), {IO_REGION, 26'($urandom), 2'b00}, $urandom);
        add_entry(sw_rs9, wb_rd9, pc_value(1'b0), data_addr(2'd0), $urandom);
        add_entry(encode(OPC_STORE, F3_SW, 5'd0, 5'd0), encode(OPC_ARI_RTYPE, 3'd0, 5'd0, 5'd3),
                  pc_value(1'b0), data_addr(2'd0), $urandom);
        add_entry(sw_rs9, encode(OPC_STORE, F3_SW, 5'd9, 5'd4), pc_value(1'b0),
                  data_addr(2'd0), $urandom);
        add_entry(sw_rs9, encode(OPC_BRANCH, F3_BEQ, 5'd9, 5'd4), pc_value(1'b0),
                  data_addr(2'd0), $urandom);
        add_entry(encode(OPC_STORE, F3_SW, 5'd0, 5'd10), wb_rd9, pc_value(1'b0),
                  data_addr(2'd0), $urandom);
        add_entry(encode(OPC_STORE, F3_SB, 5'd0, 5'd9), encode(OPC_LOAD, F3_LW, 5'd9, 5'd0),
                  pc_value(1'b0), data_addr(2'd3), $urandom);
        add_entry(encode(OPC_STORE, F3_SH, 5'd0, 5'd9), encode(OPC_JAL, 3'd0, 5'd9, 5'd0),
                  pc_value(1'b0), data_addr(2'd2), $urandom);
        // Odd offsets get negative bytes
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                rdv = $urandom;
                rdv = off[0] ? (rdv | 32'h80808080) : (rdv & 32'h7f7f7f7f);
                add_entry(encode(OPC_LOAD, kinds[k], 5'd5, 5'd0), wb_nop, pc_value(1'b0),
                          data_addr(2'(off)), rdv);
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            add_entry(encode(OPC_BRANCH, 3'(f3), 5'd0, 5'd2), wb_nop, pc_value(1'b0),
                      data_addr(2'd0), $urandom);
        end
        for (int k = 0; k < 6; k++) begin
            add_entry(encode(others[k], 3'd0, 5'd5, 5'd2), wb_nop, pc_value(1'b0),
                      data_addr(2'd1), $urandom);
        end
        for (int p = 0; p < 4; p++) begin
            add_entry(encode(OPC_STORE, 3'($urandom % 3), 5'd0, 5'd7), wb_nop, pc_value(p[0]),
                      data_addr(2'($urandom)), $urandom);
            add_entry(encode(OPC_LOAD, kinds[$urandom % 5], 5'd5, 5'd0), wb_nop,
                      pc_value(1'b0), data_addr(2'($urandom)), $urandom);
        end
    endtask

    function automatic expect_t model(entry_t e);
        expect_t     x;
        logic [4:0]  opc;
        logic [4:0]  wb_opc;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [31:0] sdata;
        logic [7:0]  b;
        logic [15:0] h;
        logic        fwd;
        opc     = e.inst[6:2];
        wb_opc  = e.wb_inst[6:2];
        f3      = e.inst[14:12];
        off     = e.addr[1:0];
        x.mask  = 4'b0000;
        x.waddr = {e.addr[31:2], 2'b00};
        x.wdata = 32'd0;
        x.tgt   = TGT_NONE;
        x.ld_v  = 1'b0;
        x.ld_d  = 32'd0;
        x.raddr = e.addr;
        x.br    = (opc == OPC_BRANCH) && (f3 != 3'd2) && (f3 != 3'd3);
        if (opc == OPC_STORE && f3 <= 3'd2) begin
            fwd = (wb_opc inside {OPC_ARI_RTYPE, OPC_ARI_ITYPE, OPC_LOAD, OPC_JAL, OPC_JALR,
                                  OPC_LUI, OPC_AUIPC})
               && (e.wb_inst[11:7] != 5'd0) && (e.wb_inst[11:7] == e.inst[24:20]);
            sdata = fwd ? e.wb_data : e.rs2_data;
            if (e.addr[31:28] == IO_REGION) begin
                x.tgt = TGT_IO;
            end else if (e.pc[30]) begin
                x.tgt = TGT_IMEM;
            end else begin
                x.tgt = TGT_DMEM;
            end
            case (f3)
                3'd0: begin
                    x.mask  = 4'b0001 << off;
                    x.wdata = {24'd0, sdata[7:0]} << (8 * off);
                end
                3'd1: begin
                    x.mask  = off[1] ? 4'b1100 : 4'b0011;
                    x.wdata = {16'd0, sdata[15:0]} << (16 * off[1]);
                end
                default: begin
                    x.mask  = 4'b1111;
                    x.wdata = sdata;
                end
            endcase
        end
        if (opc == OPC_LOAD && (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})) begin
            x.ld_v = 1'b1;
            b      = e.rd_data[8 * off +: 8];
            h      = e.rd_data[16 * off[1] +: 16];
            case (f3)
                3'd0:    x.ld_d = {{24{b[7]}}, b};
                3'd4:    x.ld_d = {24'd0, b};
                3'd1:    x.ld_d = {{16{h[15]}}, h};
                3'd5:    x.ld_d = {16'd0, h};
                default: x.ld_d = e.rd_data;
            endcase
        end
        return x;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic write_request_check(input int idx, input logic [3:0] mask,
                                       input logic [31:0] w_addr, input logic [31:0] w_data,
                                       input mem_target_t tgt, input expect_t x);
        logic [31:0] lanes;
        lanes = {{8{x.mask[3]}}, {8{x.mask[2]}}, {8{x.mask[1]}}, {8{x.mask[0]}}};
        if (mask !== x.mask) begin
            report_mismatch($sformatf("entry %0d wr_mask %b, expected %b", idx, mask, x.mask));
        end
        if (tgt !== x.tgt) begin
            report_mismatch($sformatf("entry %0d target %b, expected %b", idx, tgt, x.tgt));
        end
        if (x.mask != 4'b0000) begin
            if (w_addr !== x.waddr) begin
                report_mismatch($sformatf("entry %0d wr_addr %h, expected %h",
                                          idx, w_addr, x.waddr));
            end
            if ((w_data & lanes) !== (x.wdata & lanes)) begin
                report_mismatch($sformatf("entry %0d wr_data %h, expected %h under mask %b",
                                          idx, w_data, x.wdata, x.mask));
            end
        end
    endtask

    task automatic load_data_check(input int idx, input logic valid, input logic [31:0] data,
                                   input expect_t x);
        if (valid !== x.ld_v) begin
            report_mismatch($sformatf("entry %0d ld_valid %b, expected %b", idx, valid, x.ld_v));
        end
        if (x.ld_v && data !== x.ld_d) begin
            report_mismatch($sformatf("entry %0d ld_data %h, expected %h", idx, data, x.ld_d));
        end
    endtask

    task automatic read_address_check(input int idx, input logic [31:0] r_addr,
                                      input logic [31:0] exp_addr);
        if (r_addr !== exp_addr) begin
            report_mismatch($sformatf("entry %0d rd_addr %h, expected %h",
                                      idx, r_addr, exp_addr));
        end
    endtask

    task automatic branch_flag_check(input int idx, input logic br, input logic exp_br);
        if (br !== exp_br) begin
            report_mismatch($sformatf("entry %0d br_inst %b, expected %b", idx, br, exp_br));
        end
    endtask

    task automatic apply_entry(input entry_t e, input logic valid);
        inst_valid = valid;
        inst       = e.inst;
        wb_inst    = e.wb_inst;
        pc         = e.pc;
        addr       = e.addr;
        rs2_data   = e.rs2_data;
        wb_data    = e.wb_data;
    endtask

    initial begin
        entry_t  idle;
        expect_t prev_x;
        expect_t cur_x;
        int      n;
        void'($urandom(27619));
        inst_valid = 1'b0;
        pc         = 32'd0;
        addr       = 32'd0;
        inst       = NOP;
        wb_inst    = NOP;
        rs2_data   = 32'd0;
        wb_data    = 32'd0;
        rd_data    = 32'd0;
        build_table();
        table_ready  = 1'b1;
        idle         = '{default: '0};
        idle.inst    = NOP;
        idle.wb_inst = NOP;
        prev_x       = model(idle);
        n            = table_q.size();
        wait (arst_n === 1'b1);
        // Outputs of entry i-1 are checked while entry i is in the stage
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            #1;
            if (i < n) begin
                apply_entry(table_q[i], 1'b1);
                cur_x = model(table_q[i]);
            end else begin
                apply_entry(idle, 1'b0);
                cur_x = model(idle);
            end
            rd_data = (i > 0) ? table_q[i - 1].rd_data : 32'd0;
            #2;
            branch_flag_check(i, br_inst, cur_x.br);
            read_address_check(i, rd_addr, cur_x.raddr);
            write_request_check(i - 1, wr_mask, wr_addr, wr_data,
                                mem_target_t'({io_en, imem_en, dmem_en}), prev_x);
            load_data_check(i - 1, ld_valid, ld_data, prev_x);
            prev_x = cur_x;
        end
        @(posedge clk);
        if (DUT.u_props.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d bound assertions failed", DUT.u_props.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        wait (table_ready);
        #((table_q.size() + 40) * 10);
        $display("Watchdog expired before the stimulus table was finished");
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- dv/rv_mem_stage_properties.sv
`timescale 1ns/1ns

module rv_mem_stage_properties import rv_isa_pkg::*; (
    input logic        clk,
    input logic        arst_n,
    input logic        inst_valid,
    input logic [31:0] inst,
    input logic        br_inst,
    input logic [3:0]  wr_mask,
    input logic        dmem_en,
    input logic        imem_en,
    input logic        io_en,
    input logic        ld_valid
);

    int   fail_count = 0;
    logic any_en;
    logic load_accept;

    assign any_en      = dmem_en || imem_en || io_en;
    assign load_accept = inst_valid && (inst[6:2] == OPC_LOAD)
                      && (inst[14:12] inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});

    enables_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({dmem_en, imem_en, io_en}))
        else begin
            $error("more than one store enable is high");
            fail_count++;
        end

    mask_with_enable: assert property (@(posedge clk) disable iff (!arst_n)
        (wr_mask != 4'b0000) == any_en)
        else begin
            $error("wr_mask and store enables disagree");
            fail_count++;
        end

    // Load result needs a load one cycle back
    load_has_request: assert property (@(posedge clk) disable iff (!arst_n)
        ld_valid |-> $past(load_accept))
        else begin
            $error("ld_valid without an accepted load");
            fail_count++;
        end

    branch_no_store: assert property (@(posedge clk) disable iff (!arst_n)
        br_inst |=> !any_en)
        else begin
            $error("store enable follows a branch");
            fail_count++;
        end

endmodule

bind rv_mem_stage rv_mem_stage_properties u_props (.*);

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- rtl/rv_mem_stage.sv
`timescale 1ns/1ns

module rv_mem_stage #(
    parameter logic [3:0] IO_REGION = 4'h8
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  logic [31:0] inst,
    input  logic [31:0] wb_inst,
    input  logic [31:0] rs2_data,
    input  logic [31:0] wb_data,
    input  logic [31:0] rd_data,
    output logic        br_inst,
    output logic [31:0] rd_addr,
    output logic [31:0] wr_addr,
    output logic [31:0] wr_data,
    output logic [3:0]  wr_mask,
    output logic        dmem_en,
    output logic        imem_en,
    output logic        io_en,
    output logic [31:0] ld_data,
    output logic        ld_valid
);

    mem_ctrl_if ctrl_bus (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mem_control #(
        .IO_REGION (IO_REGION)
    ) u_mem_control (
        .inst_valid (inst_valid),
        .pc         (pc),
        .addr       (addr),
        .inst       (inst),
        .wb_inst    (wb_inst),
        .br_inst    (br_inst),
        .bus        (ctrl_bus.ctrl)
    );

    store_align u_store_align (
        .bus      (ctrl_bus.store_side),
        .addr     (addr),
        .rs2_data (rs2_data),
        .wb_data  (wb_data),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_mask  (wr_mask),
        .dmem_en  (dmem_en),
        .imem_en  (imem_en),
        .io_en    (io_en)
    );

    load_align u_load_align (
        .bus      (ctrl_bus.load_side),
        .addr     (addr),
        .rd_data  (rd_data),
        .ld_data  (ld_data),
        .ld_valid (ld_valid)
    );

    // Synchronous read memory is addressed straight from the stage
    assign rd_addr = addr;

endmodule

//--- rtl/load_align.sv
`timescale 1ns/1ns

module load_align import mem_map_pkg::*; (
    mem_ctrl_if.load_side bus,
    input  logic [31:0]   addr,
    input  logic [31:0]   rd_data,
    output logic [31:0]   ld_data,
    output logic          ld_valid
);

    logic       ld_pend;
    load_kind_t kind_q;
    logic [1:0] off_q;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    always_ff @(posedge bus.clk or negedge bus.arst_n) begin
        if (!bus.arst_n) begin
            ld_pend <= 1'b0;
        end else begin
            ld_pend <= bus.valid && bus.is_load;
        end
    end

    always_ff @(posedge bus.clk) begin
        if (bus.valid && bus.is_load) begin
            kind_q <= bus.load_kind;
            off_q  <= addr[1:0];
        end
    end

    assign byte_sel = rd_data[{off_q, 3'b000} +: 8];
    assign half_sel = off_q[1] ? rd_data[31:16] : rd_data[15:0];

    always_comb begin
        case (kind_q)
            LD_LB:   ld_data = {{24{byte_sel[7]}}, byte_sel};
            LD_LBU:  ld_data = {24'd0, byte_sel};
            LD_LH:   ld_data = {{16{half_sel[15]}}, half_sel};
            LD_LHU:  ld_data = {16'd0, half_sel};
            default: ld_data = rd_data;
        endcase
    end

    // Read data lands the cycle after the request
    assign ld_valid = ld_pend;

endmodule

//--- rtl/store_align.sv
`timescale 1ns/1ns

module store_align import mem_map_pkg::*; (
    mem_ctrl_if.store_side bus,
    input  logic [31:0]    addr,
    input  logic [31:0]    rs2_data,
    input  logic [31:0]    wb_data,
    output logic [31:0]    wr_addr,
    output logic [31:0]    wr_data,
    output logic [3:0]     wr_mask,
    output logic           dmem_en,
    output logic           imem_en,
    output logic           io_en
);

    logic [31:0] store_data;
    logic [31:0] lane_data;
    logic [3:0]  lane_mask;
    logic        store_req;

    assign store_data = bus.din_sel ? wb_data : rs2_data;
    assign store_req  = bus.valid && (bus.target != TGT_NONE) && (bus.size != SIZE_NONE);

    always_comb begin
        case (bus.size)
            SIZE_BYTE: begin
                lane_data = {4{store_data[7:0]}};
                lane_mask = 4'b0001 << addr[1:0];
            end
            SIZE_HALF: begin
                lane_data = {2{store_data[15:0]}};
                lane_mask = addr[1] ? 4'b1100 : 4'b0011;
            end
            SIZE_WORD: begin
                lane_data = store_data;
                lane_mask = 4'b1111;
            end
            default: begin
                lane_data = store_data;
                lane_mask = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge bus.clk or negedge bus.arst_n) begin
        if (!bus.arst_n) begin
            wr_mask <= 4'b0000;
            dmem_en <= 1'b0;
            imem_en <= 1'b0;
            io_en   <= 1'b0;
        end else if (store_req) begin
            wr_mask <= lane_mask;
            dmem_en <= bus.target[0];
            imem_en <= bus.target[1];
            io_en   <= bus.target[2];
        end else begin
            wr_mask <= 4'b0000;
            dmem_en <= 1'b0;
            imem_en <= 1'b0;
            io_en   <= 1'b0;
        end
    end

    // Payload only moves with a store
    always_ff @(posedge bus.clk) begin
        if (store_req) begin
            wr_addr <= {addr[31:2], 2'b00};
            wr_data <= lane_data;
        end
    end

endmodule

//--- rtl/mem_control.sv
`timescale 1ns/1ns

module mem_control import rv_isa_pkg::*, mem_map_pkg::*; #(
    parameter logic [3:0] IO_REGION = 4'h8
) (
    input  logic        inst_valid,
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  rv_inst_u    inst,
    input  rv_inst_u    wb_inst,
    output logic        br_inst,
    mem_ctrl_if.ctrl    bus
);

    opcode_t    opcode;
    opcode_t    wb_opcode;
    logic [2:0] funct3;
    mem_size_t  size_dec;
    logic       store_ok;
    logic       load_ok;
    load_kind_t kind_dec;
    logic       wb_writes_rd;

    assign opcode    = opcode_t'(inst.rtype.opcode[6:2]);
    assign wb_opcode = opcode_t'(wb_inst.rtype.opcode[6:2]);
    assign funct3    = inst.rtype.funct3;

    always_comb begin
        size_dec = SIZE_NONE;
        load_ok  = 1'b0;
        kind_dec = LD_LW;
        br_inst  = 1'b0;
        case (opcode)
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   size_dec = SIZE_BYTE;
                    F3_SH:   size_dec = SIZE_HALF;
                    F3_SW:   size_dec = SIZE_WORD;
                    default: size_dec = SIZE_NONE;
                endcase
            end
            OPC_LOAD: begin
                load_ok = 1'b1;
                case (funct3)
                    F3_LB:   kind_dec = LD_LB;
                    F3_LH:   kind_dec = LD_LH;
                    F3_LW:   kind_dec = LD_LW;
                    F3_LBU:  kind_dec = LD_LBU;
                    F3_LHU:  kind_dec = LD_LHU;
                    default: load_ok  = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: br_inst = 1'b1;
                    default: br_inst = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign store_ok = (size_dec != SIZE_NONE);

    // Previous instruction actually writes a destination register
    assign wb_writes_rd = wb_opcode inside {OPC_ARI_RTYPE, OPC_ARI_ITYPE, OPC_LOAD,
                                            OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};

    always_comb begin
        bus.target = TGT_NONE;
        if (inst_valid && store_ok) begin
            if (addr[31:28] == IO_REGION) begin
                bus.target = TGT_IO;
            end else if (pc[30]) begin
                bus.target = TGT_IMEM;
            end else begin
                bus.target = TGT_DMEM;
            end
        end
    end

    assign bus.valid     = inst_valid;
    assign bus.size      = inst_valid ? size_dec : SIZE_NONE;
    assign bus.is_load   = inst_valid && load_ok;
    assign bus.load_kind = kind_dec;

    // Store data hazard on rs2
    assign bus.din_sel = store_ok && wb_writes_rd
                      && (wb_inst.rtype.rd != 5'd0)
                      && (wb_inst.rtype.rd == inst.stype.rs2);

endmodule

//--- rtl/mem_ctrl_if.sv
`timescale 1ns/1ns

interface mem_ctrl_if import mem_map_pkg::*; (
    input logic clk,
    input logic arst_n
);

    mem_size_t   size;
    mem_target_t target;
    logic        din_sel;
    logic        is_load;
    load_kind_t  load_kind;
    logic        valid;

    modport ctrl (
        output size, target, din_sel, is_load, load_kind, valid
    );

    modport store_side (
        input clk, arst_n, size, target, din_sel, valid
    );

    modport load_side (
        input clk, arst_n, is_load, load_kind, valid
    );

endinterface

//--- rtl/mem_map_pkg.sv
package mem_map_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } mem_size_t;

    // Encoded as the load funct3
    typedef enum logic [2:0] {
        LD_LB  = 3'b000,
        LD_LH  = 3'b001,
        LD_LW  = 3'b010,
        LD_LBU = 3'b100,
        LD_LHU = 3'b101
    } load_kind_t;

    // One-hot store target, zero when no store
    typedef enum logic [2:0] {
        TGT_NONE = 3'b000,
        TGT_DMEM = 3'b001,
        TGT_IMEM = 3'b010,
        TGT_IO   = 3'b100
    } mem_target_t;

endpackage

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcode, inst[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_ARI_ITYPE = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_ARI_RTYPE = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011
    } opcode_t;

    // Loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // Stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Register and immediate arithmetic
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } stype_t;

    // One instruction word, two field layouts
    typedef union packed {
        rtype_t rtype;
        stype_t stype;
    } rv_inst_u;

endpackage
